/* rtl/swap_pkg.sv */
package swap_pkg;

    // ********************
    // line geometry
    // ********************
    localparam int H_ACT         = 16;                 // pixels per line.
    localparam int V_ACT         = 8;                  // rows per frame.
    localparam int COL_W         = $clog2(H_ACT);
    localparam int ROW_W         = $clog2(V_ACT);
    localparam int BYTES_PER_PIX = 3;
    localparam int PIX_W         = 8 * BYTES_PER_PIX;  // packed r, g, b.
    localparam int BYTE_W        = $clog2(BYTES_PER_PIX);
    localparam int GAP_CYCLES    = H_ACT;              // pause between the two lines.
    localparam int GAP_W         = $clog2(GAP_CYCLES);
    localparam int CNT_W         = 4;

    // ********************
    // bus words
    // ********************
    typedef struct packed {
        logic             valid;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
        logic [7:0]       red;
        logic [7:0]       green;
        logic [7:0]       blue;
    } cam_pack_t;

    typedef struct packed {
        logic             valid;
        logic [7:0]       data;
        logic [ROW_W-1:0] row;
        logic             cam_id;   // 0 is camera a.
    } rd_beat_t;

    typedef enum logic [2:0] {
        IDLE,
        START_A,
        WAIT_A,
        GAP,
        START_B,
        WAIT_B
    } seq_state_t;

endpackage : swap_pkg

/* rtl/swap_sequencer.sv */
module swap_sequencer (
    input  logic                       rclk,
    input  logic                       rstn,
    input  logic                       trig,
    input  logic                       read_done,
    input  logic                       gap_done,
    output logic                       cam_id,
    output logic                       cap_start,
    output logic                       gap_start,
    output logic [swap_pkg::CNT_W-1:0] trig_cnt
);
    import swap_pkg::*;

    seq_state_t state;
    logic       pending;   // one trigger held while busy.

    assign cam_id = (state == START_B) || (state == WAIT_B);

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            pending <= 1'b0;
        end else if (state == IDLE) begin
            pending <= 1'b0;   // served on the way out of idle.
        end else if (trig) begin
            pending <= 1'b1;   // a second one is simply lost.
        end
    end

    // ********************
    // camera sequence
    // ********************
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state     <= IDLE;
            cap_start <= 1'b0;
            gap_start <= 1'b0;
            trig_cnt  <= '0;
        end else begin
            cap_start <= 1'b0;
            gap_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (trig || pending) begin
                        state     <= START_A;
                        cap_start <= 1'b1;
                        trig_cnt  <= trig_cnt + 1'b1;   // wraps.
                    end
                end
                START_A: begin
                    state <= WAIT_A;
                end
                WAIT_A: begin
                    if (read_done) begin
                        state     <= GAP;
                        gap_start <= 1'b1;
                    end
                end
                GAP: begin
                    if (gap_done) begin
                        state     <= START_B;
                        cap_start <= 1'b1;
                    end
                end
                START_B: begin
                    state <= WAIT_B;
                end
                WAIT_B: begin
                    if (read_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    a_read_done_state: assert property (@(posedge rclk) disable iff (!rstn)
        read_done |-> (state inside {WAIT_A, WAIT_B}));

endmodule : swap_sequencer

/* rtl/gap_timer.sv */
module gap_timer (
    input  logic rclk,
    input  logic rstn,
    input  logic gap_start,
    output logic gap_done
);
    import swap_pkg::*;

    logic [GAP_W-1:0] cnt;
    logic             running;

    assign gap_done = running && (cnt == '0);

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            running <= 1'b0;
            cnt     <= '0;
        end else if (gap_start) begin
            running <= 1'b1;
            cnt     <= GAP_W'(GAP_CYCLES - 1);
        end else if (running) begin
            if (cnt == '0) begin
                running <= 1'b0;   // done strobe this cycle.
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    a_no_restart: assert property (@(posedge rclk) disable iff (!rstn)
        gap_start |-> !running);

endmodule : gap_timer

/* rtl/line_capture.sv */
module line_capture (
    input  logic                       rclk,
    input  logic                       rstn,
    input  swap_pkg::cam_pack_t        cam_a,
    input  swap_pkg::cam_pack_t        cam_b,
    input  logic                       cam_id,
    input  logic                       cap_start,
    output logic                       wr_en,
    output logic [swap_pkg::COL_W-1:0] wr_addr,
    output logic [swap_pkg::PIX_W-1:0] wr_pixel,
    output logic                       line_ready,
    output logic [swap_pkg::ROW_W-1:0] line_row,
    output logic                       error
);
    import swap_pkg::*;

    cam_pack_t        cam;
    logic             armed;     // looking for column 0.
    logic             busy;      // rest of the line.
    logic [COL_W-1:0] exp_col;
    logic             first;
    logic             last;

    assign cam      = cam_id ? cam_b : cam_a;
    assign first    = armed && cam.valid && (cam.col == '0);
    assign last     = busy && cam.valid && (exp_col == COL_W'(H_ACT - 1));
    assign wr_en    = first || (busy && cam.valid);
    assign wr_addr  = busy ? exp_col : '0;
    assign wr_pixel = {cam.red, cam.green, cam.blue};

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            armed      <= 1'b0;
            busy       <= 1'b0;
            exp_col    <= '0;
            line_ready <= 1'b0;
            error      <= 1'b0;
        end else begin
            line_ready <= last;   // cycle after the last write.
            if (cap_start) begin
                armed <= 1'b1;
            end
            if (first) begin
                armed   <= 1'b0;
                busy    <= 1'b1;
                exp_col <= COL_W'(1);
            end else if (busy && cam.valid) begin
                exp_col <= exp_col + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                end
            end
            if (busy && cam.valid && (cam.col != exp_col)) begin
                error <= 1'b1;   // sticky.
            end
        end
    end

    always_ff @(posedge rclk) begin
        if (first) begin
            line_row <= cam.row;
        end
    end

endmodule : line_capture

/* rtl/line_ram.sv */
module line_ram (
    input  logic                       rclk,
    input  logic                       wr_en,
    input  logic [swap_pkg::COL_W-1:0] wr_addr,
    input  logic [swap_pkg::PIX_W-1:0] wr_pixel,
    input  logic [swap_pkg::COL_W-1:0] rd_addr,
    output logic [swap_pkg::PIX_W-1:0] rd_pixel
);
    import swap_pkg::*;

    logic [PIX_W-1:0] mem [H_ACT];

    always_ff @(posedge rclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_pixel;
        end
    end

    // one cycle read latency.
    always_ff @(posedge rclk) begin
        rd_pixel <= mem[rd_addr];
    end

endmodule : line_ram

/* rtl/line_reader.sv */
module line_reader (
    input  logic                       rclk,
    input  logic                       rstn,
    input  logic                       line_ready,
    input  logic [swap_pkg::ROW_W-1:0] line_row,
    input  logic                       cam_id,
    input  logic                       read_en,
    output logic [swap_pkg::COL_W-1:0] rd_addr,
    input  logic [swap_pkg::PIX_W-1:0] rd_pixel,
    output logic                       aquire,
    output swap_pkg::rd_beat_t         rd_beat,
    output logic                       read_done
);
    import swap_pkg::*;

    logic [COL_W-1:0]  pix_idx;
    logic [BYTE_W-1:0] byte_idx;
    logic [BYTE_W-1:0] sel;        // byte of the beat in flight.
    logic              take;
    logic              pix_end;
    logic              last;
    logic              beat_valid;
    logic [ROW_W-1:0]  row_q;
    logic              cam_q;

    assign take    = aquire && read_en;
    assign pix_end = (byte_idx == BYTE_W'(BYTES_PER_PIX - 1));
    assign last    = take && pix_end && (pix_idx == COL_W'(H_ACT - 1));
    assign rd_addr = pix_idx;

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            aquire     <= 1'b0;
            read_done  <= 1'b0;
            beat_valid <= 1'b0;
            pix_idx    <= '0;
            byte_idx   <= '0;
        end else begin
            read_done  <= last;
            beat_valid <= take;
            if (line_ready) begin
                aquire   <= 1'b1;
                pix_idx  <= '0;
                byte_idx <= '0;
            end else if (take) begin
                if (last) begin
                    aquire  <= 1'b0;
                    pix_idx <= '0;
                end else if (pix_end) begin
                    pix_idx <= pix_idx + 1'b1;
                end
                byte_idx <= pix_end ? '0 : byte_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge rclk) begin
        if (take) begin
            sel <= byte_idx;
        end
        if (line_ready) begin
            row_q <= line_row;
            cam_q <= cam_id;
        end
    end

    // red sits in the top byte.
    assign rd_beat.valid  = beat_valid;
    assign rd_beat.data   = rd_pixel[PIX_W - 8 - 8 * int'(sel) +: 8];
    assign rd_beat.row    = row_q;
    assign rd_beat.cam_id = cam_q;

    a_no_overrun: assert property (@(posedge rclk) disable iff (!rstn)
        line_ready |-> !aquire);

endmodule : line_reader

/* rtl/dual_cam_line_swap.sv */
module dual_cam_line_swap (
    input  logic                       rclk,
    input  logic                       rstn,
    input  logic                       trig,
    input  swap_pkg::cam_pack_t        cam_a,
    input  swap_pkg::cam_pack_t        cam_b,
    input  logic                       read_en,
    output logic                       aquire,
    output swap_pkg::rd_beat_t         rd_beat,
    output logic [swap_pkg::CNT_W-1:0] trig_cnt,
    output logic                       error
);
    import swap_pkg::*;

    logic             cam_id;
    logic             cap_start;
    logic             gap_start;
    logic             gap_done;
    logic             read_done;
    logic             wr_en;
    logic [COL_W-1:0] wr_addr;
    logic [PIX_W-1:0] wr_pixel;
    logic             line_ready;
    logic [ROW_W-1:0] line_row;
    logic [COL_W-1:0] rd_addr;
    logic [PIX_W-1:0] rd_pixel;

    // ********************
    // control
    // ********************
    swap_sequencer u_seq (
        .rclk      (rclk),
        .rstn      (rstn),
        .trig      (trig),
        .read_done (read_done),
        .gap_done  (gap_done),
        .cam_id    (cam_id),
        .cap_start (cap_start),
        .gap_start (gap_start),
        .trig_cnt  (trig_cnt)
    );

    gap_timer u_gap (
        .rclk      (rclk),
        .rstn      (rstn),
        .gap_start (gap_start),
        .gap_done  (gap_done)
    );

    // ********************
    // data path
    // ********************
    line_capture u_cap (
        .rclk       (rclk),
        .rstn       (rstn),
        .cam_a      (cam_a),
        .cam_b      (cam_b),
        .cam_id     (cam_id),
        .cap_start  (cap_start),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_pixel   (wr_pixel),
        .line_ready (line_ready),
        .line_row   (line_row),
        .error      (error)
    );

    line_ram u_ram (
        .rclk     (rclk),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_pixel (wr_pixel),
        .rd_addr  (rd_addr),
        .rd_pixel (rd_pixel)
    );

    line_reader u_rd (
        .rclk       (rclk),
        .rstn       (rstn),
        .line_ready (line_ready),
        .line_row   (line_row),
        .cam_id     (cam_id),
        .read_en    (read_en),
        .rd_addr    (rd_addr),
        .rd_pixel   (rd_pixel),
        .aquire     (aquire),
        .rd_beat    (rd_beat),
        .read_done  (read_done)
    );

endmodule : dual_cam_line_swap

/* verification/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ********************
// model and checks
// ********************
function automatic logic [23:0] model_pixel(input int cam, input int row, input int col);
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    r = 8'(cam * 128 + row * 16 + col);
    g = 8'(col * 17 + row * 3 + 1);
    b = 8'(cam * 64 + row * 29 + col * 5) ^ 8'h3c;
    return {r, g, b};
endfunction

task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
endtask

task automatic abort_on_timeout(input string what);
    errors++;
    $display("timeout at %0t: %s", $time, what);
    end_run();
endtask

task automatic pulse_trig();
    @(negedge rclk);
    trig = 1'b1;
    @(negedge rclk);
    trig = 1'b0;
endtask

task automatic wait_aquire();
    int cycles;
    cycles = 0;
    while (!aquire && cycles < WAIT_LIMIT) begin
        @(negedge rclk);
        cycles++;
    end
    if (!aquire) begin
        abort_on_timeout("no line was offered to the reader");
    end
endtask

// read_en held high with no line waiting.
task automatic idle_reads(input int cycles);
    read_en = 1'b1;
    repeat (cycles) begin
        @(negedge rclk);
        compare_value("aquire", 32'(aquire), 32'd0);
        compare_value("rd_beat.valid", 32'(rd_beat.valid), 32'd0);
    end
    read_en = 1'b0;
endtask

task automatic read_line(input int cam, input bit check_data, input bit gaps);
    int          sent;
    int          got;
    int          cycles;
    int          row;
    bit          prev_en;
    logic [23:0] pix;
    sent    = 0;
    got     = 0;
    cycles  = 0;
    prev_en = 1'b0;
    wait_aquire();
    // camera has just moved past the stored line.
    row = (cam_row[cam] + V_ACT - 1) % V_ACT;
    while (got < LINE_BYTES && cycles < READ_LIMIT) begin
        @(negedge rclk);
        cycles++;
        compare_value("rd_beat.valid", 32'(rd_beat.valid), 32'(prev_en));
        if (rd_beat.valid) begin
            pix = model_pixel(cam, row, got / BYTES_PER_PIX);
            compare_value("rd_beat.row", 32'(rd_beat.row), 32'(row));
            compare_value("rd_beat.cam_id", 32'(rd_beat.cam_id), 32'(cam));
            if (check_data) begin
                compare_value("rd_beat.data", 32'(rd_beat.data),
                              32'(8'(pix >> (16 - 8 * (got % BYTES_PER_PIX)))));
            end
            got++;
        end
        prev_en = (sent < LINE_BYTES) && !(gaps && $urandom_range(2) == 0);
        read_en = prev_en;
        if (prev_en) begin
            sent++;
        end
    end
    read_en = 1'b0;
    if (got < LINE_BYTES) begin
        abort_on_timeout("line readout did not complete");
    end else begin
        compare_value("aquire", 32'(aquire), 32'd0);
    end
endtask

// ********************
// directed tests
// ********************
task automatic reset_values_test();
    compare_value("aquire", 32'(aquire), 32'd0);
    compare_value("rd_beat.valid", 32'(rd_beat.valid), 32'd0);
    compare_value("error", 32'(error), 32'd0);
    compare_value("trig_cnt", 32'(trig_cnt), 32'd0);
endtask

task automatic one_trigger_test(input bit gaps);
    logic [CNT_W-1:0] start;
    start = trig_cnt;
    if (gaps) begin
        idle_reads(10);
    end
    pulse_trig();
    read_line(0, 1'b1, gaps);
    read_line(1, 1'b1, gaps);
    compare_value("trig_cnt", 32'(trig_cnt), 32'(CNT_W'(start + 1'b1)));
endtask

task automatic busy_triggers_test();
    logic [CNT_W-1:0] start;
    start = trig_cnt;
    pulse_trig();
    wait_aquire();
    pulse_trig();
    pulse_trig();   // already one pending.
    repeat (2) begin
        read_line(0, 1'b1, 1'b0);
        read_line(1, 1'b1, 1'b0);
    end
    compare_value("trig_cnt", 32'(trig_cnt), 32'(CNT_W'(start + 2'd2)));
    idle_reads(4 * H_ACT);
endtask

task automatic column_skip_test();
    compare_value("error", 32'(error), 32'd0);
    skip_b = 1'b1;
    pulse_trig();
    read_line(0, 1'b1, 1'b0);
    compare_value("error", 32'(error), 32'd0);
    read_line(1, 1'b0, 1'b0);   // bytes of the broken line go unchecked.
    compare_value("error", 32'(error), 32'd1);
    skip_b = 1'b0;
    pulse_trig();
    read_line(0, 1'b1, 1'b0);
    read_line(1, 1'b1, 1'b0);
    compare_value("error", 32'(error), 32'd1);
endtask

`endif

/* verification/tb_line_swap.sv */
module tb_line_swap;
    import swap_pkg::*;

    localparam int LINE_BYTES = H_ACT * BYTES_PER_PIX;
    localparam int IDLE_WORDS = 3;                // blank words between camera lines.
    localparam int WAIT_LIMIT = 400;
    localparam int READ_LIMIT = 20 * LINE_BYTES;

    logic             rclk = 1'b0;
    logic             rstn;
    logic             trig;
    logic             read_en;
    cam_pack_t        cam_a = '0;
    cam_pack_t        cam_b = '0;
    logic             aquire;
    rd_beat_t         rd_beat;
    logic [CNT_W-1:0] trig_cnt;
    logic             error;

    int        errors;
    int        checks;
    bit        skip_b;                            // camera b drops column 5.
    int        cam_row[2] = '{0, 3};
    int        cam_col[2] = '{0, 0};
    int        cam_idle[2] = '{0, 7};             // cameras out of phase.
    cam_pack_t cam_word[2];

    `include "tb_tasks.svh"

    dual_cam_line_swap DUT (
        .rclk     (rclk),
        .rstn     (rstn),
        .trig     (trig),
        .cam_a    (cam_a),
        .cam_b    (cam_b),
        .read_en  (read_en),
        .aquire   (aquire),
        .rd_beat  (rd_beat),
        .trig_cnt (trig_cnt),
        .error    (error)
    );

    always #4 rclk = ~rclk;

    // ********************
    // camera models
    // ********************
    always @(negedge rclk) begin
        for (int c = 0; c < 2; c++) begin
            if (cam_idle[c] > 0) begin
                cam_word[c] = '0;
                cam_idle[c]--;
            end else begin
                cam_word[c].valid = 1'b1;
                cam_word[c].row   = ROW_W'(cam_row[c]);
                cam_word[c].col   = COL_W'(cam_col[c]);
                {cam_word[c].red, cam_word[c].green, cam_word[c].blue} =
                    model_pixel(c, cam_row[c], cam_col[c]);
                if (cam_col[c] == H_ACT - 1) begin
                    cam_col[c]  = 0;
                    cam_row[c]  = (cam_row[c] + 1) % V_ACT;
                    cam_idle[c] = IDLE_WORDS;
                end else if (skip_b && c == 1 && cam_col[c] == 4) begin
                    cam_col[c] = 6;
                end else begin
                    cam_col[c]++;
                end
            end
        end
        cam_a <= cam_word[0];
        cam_b <= cam_word[1];
    end

    task automatic end_run();
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        rstn    = 1'b0;
        trig    = 1'b0;
        read_en = 1'b0;
        skip_b  = 1'b0;
        errors  = 0;
        checks  = 0;
        void'($urandom(32'h2662a003));
        repeat (5) @(negedge rclk);
        rstn = 1'b1;
        reset_values_test();
        one_trigger_test(1'b0);
        one_trigger_test(1'b1);   // random reader gaps.
        busy_triggers_test();
        column_skip_test();
        end_run();
    end

endmodule : tb_line_swap

/* project.f */
+incdir+verification
rtl/swap_pkg.sv
rtl/swap_sequencer.sv
rtl/gap_timer.sv
rtl/line_capture.sv
rtl/line_ram.sv
rtl/line_reader.sv
rtl/dual_cam_line_swap.sv
verification/tb_line_swap.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_line_swap
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
